// ==== sources.f ====
src/l2c_pkg.sv
src/l2_vr_if.sv
src/l2_if_arbiter.sv
src/l2_resp_router.sv
src/l2c_arbiter_wrapper.sv
tb/l2c_arbiter_assert.sv
tb/l2c_checker.sv
tb/tb_l2c_arbiter_wrapper.sv

// ==== Bender.yml ====
package:
  name: l2c_arbiter

sources:
  - src/l2c_pkg.sv
  - src/l2_vr_if.sv
  - src/l2_if_arbiter.sv
  - src/l2_resp_router.sv
  - src/l2c_arbiter_wrapper.sv
  - target: test
    files:
      - tb/l2c_arbiter_assert.sv
      - tb/l2c_checker.sv
      - tb/tb_l2c_arbiter_wrapper.sv

// ==== tb/tb_l2c_arbiter_wrapper.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_l2c_arbiter_wrapper
  import l2c_pkg::*;
();

  localparam int NUM_ROWS = 8;
  localparam int LIMIT    = NUM_ROWS * 40 + 20;
  localparam logic [DATA_W-1:0] FILL = 64'ha5a5_5a5a_0f0f_f0f0;

  typedef struct {
    string    name;
    bit [3:0] mask;
    bit [3:0] cmd;
    int       req_stall;
    bit [3:0] resp_stall;
    bit [3:0] resp_rdy;
  } row_t;

  row_t rows [NUM_ROWS];

  logic i_clk;
  logic i_rst;
  logic [3:0]                req_valid;
  logic [3:0]                req_cmd;
  logic [3:0][PADDR_W-1:0]   req_addr;
  logic [3:0][REQ_TAG_W-1:0] req_tag;
  logic [3:0][DATA_W-1:0]    req_data;
  logic [3:0][BYTE_EN_W-1:0] req_be;
  logic [3:0]                resp_rdy;
  wire  [3:0]                req_rdy;
  wire  [3:0]                resp_vld;
  wire  [3:0][REQ_TAG_W-1:0] resp_tag;
  wire  [3:0][DATA_W-1:0]    resp_data;
  wire                       l2_req_valid;
  wire mem_cmd_t             l2_req_cmd;
  wire [PADDR_W-1:0]         l2_req_addr;
  wire [L2_CMD_TAG_W-1:0]    l2_req_tag;
  wire [DATA_W-1:0]          l2_req_data;
  wire [BYTE_EN_W-1:0]       l2_req_be;
  wire                       l2_resp_ready;
  logic                      l2_req_ready;
  logic                      l2_resp_valid;
  logic [L2_CMD_TAG_W-1:0]   l2_resp_tag;
  logic [DATA_W-1:0]         l2_resp_data;

  int err_cnt;
  int delivered;
  int cycles;
  int req_stall;
  bit [3:0] resp_stall;
  logic [31:0] rnd_state;

  l2c_arbiter_wrapper i_l2c_arbiter_wrapper (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_elf_req_valid (req_valid[0]), .i_elf_req_cmd (mem_cmd_t'(req_cmd[0])),
    .i_elf_req_addr (req_addr[0]), .i_elf_req_tag (req_tag[0]),
    .i_elf_req_data (req_data[0]), .i_elf_req_byte_en (req_be[0]),
    .o_elf_req_ready (req_rdy[0]), .o_elf_resp_valid (resp_vld[0]),
    .o_elf_resp_tag (resp_tag[0]), .o_elf_resp_data (resp_data[0]),
    .i_elf_resp_ready (resp_rdy[0]),
    .i_ic_req_valid (req_valid[1]), .i_ic_req_cmd (mem_cmd_t'(req_cmd[1])),
    .i_ic_req_addr (req_addr[1]), .i_ic_req_tag (req_tag[1]),
    .i_ic_req_data (req_data[1]), .i_ic_req_byte_en (req_be[1]),
    .o_ic_req_ready (req_rdy[1]), .o_ic_resp_valid (resp_vld[1]),
    .o_ic_resp_tag (resp_tag[1]), .o_ic_resp_data (resp_data[1]),
    .i_ic_resp_ready (resp_rdy[1]),
    .i_l1d_req_valid (req_valid[2]), .i_l1d_req_cmd (mem_cmd_t'(req_cmd[2])),
    .i_l1d_req_addr (req_addr[2]), .i_l1d_req_tag (req_tag[2]),
    .i_l1d_req_data (req_data[2]), .i_l1d_req_byte_en (req_be[2]),
    .o_l1d_req_ready (req_rdy[2]), .o_l1d_resp_valid (resp_vld[2]),
    .o_l1d_resp_tag (resp_tag[2]), .o_l1d_resp_data (resp_data[2]),
    .i_l1d_resp_ready (resp_rdy[2]),
    .i_ptw_req_valid (req_valid[3]), .i_ptw_req_cmd (mem_cmd_t'(req_cmd[3])),
    .i_ptw_req_addr (req_addr[3]), .i_ptw_req_tag (req_tag[3]),
    .i_ptw_req_data (req_data[3]), .i_ptw_req_byte_en (req_be[3]),
    .o_ptw_req_ready (req_rdy[3]), .o_ptw_resp_valid (resp_vld[3]),
    .o_ptw_resp_tag (resp_tag[3]), .o_ptw_resp_data (resp_data[3]),
    .i_ptw_resp_ready (resp_rdy[3]),
    .o_l2_req_valid (l2_req_valid), .o_l2_req_cmd (l2_req_cmd),
    .o_l2_req_addr (l2_req_addr), .o_l2_req_tag (l2_req_tag),
    .o_l2_req_data (l2_req_data), .o_l2_req_byte_en (l2_req_be),
    .i_l2_req_ready (l2_req_ready), .i_l2_resp_valid (l2_resp_valid),
    .i_l2_resp_tag (l2_resp_tag), .i_l2_resp_data (l2_resp_data),
    .o_l2_resp_ready (l2_resp_ready)
  );

  l2c_checker i_l2c_checker (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_req_valid (req_valid), .i_req_ready (req_rdy), .i_req_cmd (req_cmd),
    .i_req_addr (req_addr), .i_req_tag (req_tag), .i_req_data (req_data),
    .i_req_byte_en (req_be),
    .i_l2_req_valid (l2_req_valid), .i_l2_req_cmd (l2_req_cmd),
    .i_l2_req_addr (l2_req_addr), .i_l2_req_tag (l2_req_tag),
    .i_l2_req_data (l2_req_data), .i_l2_req_byte_en (l2_req_be),
    .i_l2_req_ready (l2_req_ready), .i_l2_resp_valid (l2_resp_valid),
    .i_l2_resp_tag (l2_resp_tag), .i_l2_resp_ready (l2_resp_ready),
    .i_resp_valid (resp_vld), .i_resp_tag (resp_tag), .i_resp_data (resp_data),
    .i_resp_ready (resp_rdy), .o_err_cnt (err_cnt), .o_delivered (delivered)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // L2 model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic [DATA_W-1:0]       l2_mem [logic [PADDR_W-1:0]];
  logic [L2_CMD_TAG_W-1:0] pend_tag [$];
  logic [DATA_W-1:0]       pend_data [$];
  int                      pend_due [$];
  int                      wait_cnt;
  bit                      resp_taken;

  always @(posedge i_clk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("*** FAILED ***");
      $finish;
    end else if (!i_rst) begin
      resp_taken = l2_resp_valid && l2_resp_ready;
      if (l2_req_valid && l2_req_ready) begin
        pend_tag.push_back(l2_req_tag);
        pend_due.push_back(cycles + 2);
        if (l2_req_cmd == M_XWR) begin
          l2_mem[l2_req_addr] = l2_req_data;
          pend_data.push_back(l2_req_data);
        end else if (l2_mem.exists(l2_req_addr)) begin
          pend_data.push_back(l2_mem[l2_req_addr]);
        end else begin
          pend_data.push_back(FILL ^ DATA_W'(l2_req_addr));
        end
        wait_cnt = 0;
      end else if (l2_req_valid) begin
        wait_cnt++;
      end
      if (resp_taken) begin
        void'(pend_tag.pop_front());
        void'(pend_data.pop_front());
        void'(pend_due.pop_front());
      end
      #1;
      if (resp_taken) begin
        l2_resp_valid = 1'b0;
      end
      l2_req_ready = (wait_cnt >= req_stall);
      if (!l2_resp_valid && pend_tag.size() > 0 && pend_due[0] <= cycles &&
          !resp_stall[cycles % 4]) begin
        l2_resp_valid = 1'b1;
        l2_resp_tag   = pend_tag[0];
        l2_resp_data  = pend_data[0];
      end
    end
  end

  task automatic load_req_payload(input int i);
    rnd_state   = xorshift(rnd_state);
    req_addr[i] = 32'h8000_0000 | (rnd_state & 32'h18);
    rnd_state   = xorshift(rnd_state);
    req_data[i] = {rnd_state, ~rnd_state};
    req_tag[i]  = REQ_TAG_W'(rnd_state >> 8);
    req_be[i]   = BYTE_EN_W'(rnd_state >> 20);
  endtask

  task automatic drive_req(input int i);
    req_valid[i] = 1'b1;
    do @(posedge i_clk); while (!req_rdy[i]);
    #1;
    req_valid[i] = 1'b0;
  endtask

  initial begin
    int expected;
    rows[0] = '{"single_elf", 4'b0001, 4'b0001, 0, 4'b0000, 4'b1111};
    rows[1] = '{"single_ic", 4'b0010, 4'b0000, 0, 4'b0000, 4'b1111};
    rows[2] = '{"single_l1d", 4'b0100, 4'b0100, 0, 4'b0000, 4'b1111};
    rows[3] = '{"single_ptw", 4'b1000, 4'b0000, 0, 4'b0000, 4'b1111};
    rows[4] = '{"all_four", 4'b1111, 4'b0101, 0, 4'b0000, 4'b1111};
    rows[5] = '{"l2_req_stall", 4'b1111, 4'b1010, 3, 4'b0000, 4'b1111};
    rows[6] = '{"read_back", 4'b1111, 4'b0000, 0, 4'b0101, 4'b1111};
    rows[7] = '{"resp_backpressure", 4'b0110, 4'b0000, 1, 4'b0000, 4'b1001};
    rnd_state = 32'd63;
    cycles = 0;
    wait_cnt = 0;
    expected = 0;
    req_stall = 0;
    resp_stall = 4'b0;
    req_valid = '0;
    req_cmd = '0;
    req_addr = '0;
    req_tag = '0;
    req_data = '0;
    req_be = '1;
    resp_rdy = '1;
    l2_req_ready = 1'b1;
    l2_resp_valid = 1'b0;
    l2_resp_tag = '0;
    l2_resp_data = '0;
    i_rst = 1'b1;
    repeat (4) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      req_stall  = rows[r].req_stall;
      resp_stall = rows[r].resp_stall;
      repeat (2) @(posedge i_clk);
      #1;
      expected  += $countones(rows[r].mask);
      resp_rdy   = rows[r].resp_rdy;
      req_cmd    = rows[r].cmd;
      for (int i = 0; i < 4; i++) begin
        if (rows[r].mask[i]) begin
          load_req_payload(i);
        end
      end
      fork
        if (rows[r].mask[0]) drive_req(0);
        if (rows[r].mask[1]) drive_req(1);
        if (rows[r].mask[2]) drive_req(2);
        if (rows[r].mask[3]) drive_req(3);
        begin
          // held-off requesters take their responses later.
          repeat (8) @(posedge i_clk);
          #1;
          resp_rdy = '1;
        end
      join
      while (delivered < expected) begin
        @(posedge i_clk);
        #2;
      end
      i_l2c_checker.report_row(rows[r].name);
    end
    i_l2c_checker.report_totals(NUM_ROWS);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/l2c_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module l2c_checker
  import l2c_pkg::*;
(
  input  wire logic                          i_clk,
  input  wire logic                          i_rst,
  input  wire logic [3:0]                    i_req_valid,
  input  wire logic [3:0]                    i_req_ready,
  input  wire logic [3:0]                    i_req_cmd,
  input  wire logic [3:0][PADDR_W-1:0]       i_req_addr,
  input  wire logic [3:0][REQ_TAG_W-1:0]     i_req_tag,
  input  wire logic [3:0][DATA_W-1:0]        i_req_data,
  input  wire logic [3:0][BYTE_EN_W-1:0]     i_req_byte_en,
  input  wire logic                          i_l2_req_valid,
  input  wire logic                          i_l2_req_cmd,
  input  wire logic [PADDR_W-1:0]            i_l2_req_addr,
  input  wire logic [L2_CMD_TAG_W-1:0]       i_l2_req_tag,
  input  wire logic [DATA_W-1:0]             i_l2_req_data,
  input  wire logic [BYTE_EN_W-1:0]          i_l2_req_byte_en,
  input  wire logic                          i_l2_req_ready,
  input  wire logic                          i_l2_resp_valid,
  input  wire logic [L2_CMD_TAG_W-1:0]       i_l2_resp_tag,
  input  wire logic                          i_l2_resp_ready,
  input  wire logic [3:0]                    i_resp_valid,
  input  wire logic [3:0][REQ_TAG_W-1:0]     i_resp_tag,
  input  wire logic [3:0][DATA_W-1:0]        i_resp_data,
  input  wire logic [3:0]                    i_resp_ready,
  output int                                 o_err_cnt,
  output int                                 o_delivered
);

  localparam logic [DATA_W-1:0] FILL = 64'ha5a5_5a5a_0f0f_f0f0;

  logic [DATA_W-1:0] mem [logic [PADDR_W-1:0]];
  l2_resp_t          exp_q [$];
  int                ptr;
  int                lock_idx;
  bit                lock;
  int                checks;
  int                row_start_err;

  task automatic check(input bit ok, input string msg);
    checks++;
    if (!ok) begin
      o_err_cnt++;
      $display("error at %0t: %s", $time, msg);
    end
  endtask

  task automatic report_row(input string name);
    $display("test %s %s (%0d errors)", name,
             (o_err_cnt == row_start_err) ? "ok" : "bad", o_err_cnt - row_start_err);
    row_start_err = o_err_cnt;
  endtask

  task automatic report_totals(input int rows);
    $display("tests %0d, checks %0d, errors %0d", rows, checks, o_err_cnt);
  endtask

  initial begin
    o_err_cnt     = 0;
    o_delivered   = 0;
    checks        = 0;
    row_start_err = 0;
  end

  always @(posedge i_clk) begin
    int       idx;
    int       dst;
    bit       found;
    l2_resp_t exp;
    if (i_rst) begin
      ptr  = 0;
      lock = 1'b0;
    end else begin
      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      // request side
      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      found = 1'b0;
      idx   = 0;
      for (int k = 0; k < 4; k++) begin
        if (!found && i_req_valid[(ptr + k) % 4]) begin
          found = 1'b1;
          idx   = (ptr + k) % 4;
        end
      end
      if (lock) begin
        idx   = lock_idx;
        found = i_req_valid[idx];
      end
      check(i_l2_req_valid == found, "o_l2_req_valid wrong");
      if (found) begin
        check(i_l2_req_tag == {SRC_ID_W'(idx), i_req_tag[idx]}, "forwarded tag wrong");
        check(i_l2_req_cmd == i_req_cmd[idx] && i_l2_req_addr == i_req_addr[idx] &&
              i_l2_req_data == i_req_data[idx] && i_l2_req_byte_en == i_req_byte_en[idx],
              "forwarded payload wrong");
      end
      check(i_req_ready == ((found && i_l2_req_ready) ? 4'(1 << idx) : 4'b0),
            "requester ready wrong");
      if (found && i_l2_req_ready) begin
        exp.tag = {SRC_ID_W'(idx), i_req_tag[idx]};
        if (i_req_cmd[idx]) begin
          mem[i_req_addr[idx]] = i_req_data[idx];
          exp.data = i_req_data[idx];
        end else begin
          exp.data = mem.exists(i_req_addr[idx]) ? mem[i_req_addr[idx]] :
                     (FILL ^ DATA_W'(i_req_addr[idx]));
        end
        exp_q.push_back(exp);
        ptr  = (idx + 1) % 4;
        lock = 1'b0;
      end else if (found) begin
        lock     = 1'b1;
        lock_idx = idx;
      end

      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      // response side
      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      if (i_l2_resp_valid) begin
        dst = int'(i_l2_resp_tag[L2_CMD_TAG_W-1 -: SRC_ID_W]);
        check(i_resp_valid == 4'(1 << dst), "response sent to wrong requester");
        check(i_l2_resp_ready == i_resp_ready[dst], "o_l2_resp_ready wrong");
        if (i_resp_ready[dst]) begin
          check(exp_q.size() > 0, "response with nothing outstanding");
          if (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            check(exp.tag == i_l2_resp_tag, "response order wrong");
            check(i_resp_tag[dst] == exp.tag[REQ_TAG_W-1:0], "local tag wrong");
            check(i_resp_data[dst] == exp.data, "response data wrong");
          end
          o_delivered++;
        end
      end else begin
        check(i_resp_valid == 4'b0, "response valid without L2 response");
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/l2c_arbiter_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module l2c_arbiter_assert #(
  parameter int ARB_NUM  = 4,
  parameter int SRC_W    = 2,
  parameter int PAYLOAD_W = 8
) (
  input wire logic                 i_clk,
  input wire logic                 i_rst,
  input wire logic                 i_valid,
  input wire logic                 i_ready,
  input wire logic [PAYLOAD_W-1:0] i_payload,
  input wire logic [ARB_NUM-1:0]   i_valid_vec,
  input wire logic [SRC_W-1:0]     i_grant_idx,
  input wire logic [SRC_W-1:0]     i_src_idx
);

  // held request keeps valid and payload.
  a_stall_stable: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_valid && !i_ready) |=> (i_valid && $stable(i_payload)))
    else $error("stalled request changed");

  // grant stays on the stalled source.
  a_grant_locked: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_valid && !i_ready) |=> (i_grant_idx == $past(i_grant_idx)))
    else $error("grant moved while locked");

  // forwarded tag names a requesting source.
  a_valid_source: assert property (@(posedge i_clk) disable iff (i_rst)
    i_valid |-> i_valid_vec[i_src_idx])
    else $error("request forwarded without a valid source");

endmodule

bind l2_if_arbiter l2c_arbiter_assert #(
  .ARB_NUM   (ARB_NUM),
  .SRC_W     (l2c_pkg::SRC_ID_W),
  .PAYLOAD_W ($bits(l2c_pkg::l2_req_t))
) i_l2c_arbiter_assert (
  .i_clk       (i_clk),
  .i_rst       (i_rst),
  .i_valid     (l2_master_if.valid),
  .i_ready     (l2_master_if.ready),
  .i_payload   (l2_master_if.payload),
  .i_valid_vec (valid_vec),
  .i_grant_idx (grant_idx),
  .i_src_idx   (fwd_req.tag[l2c_pkg::L2_CMD_TAG_W-1 -: l2c_pkg::SRC_ID_W])
);

`default_nettype wire

// ==== src/l2c_arbiter_wrapper.sv ====
`timescale 1ns/10ps
`default_nettype none

module l2c_arbiter_wrapper
  import l2c_pkg::*;
(
  input  wire logic                    i_clk,
  input  wire logic                    i_rst,

  // elf loader.
  input  wire logic                    i_elf_req_valid,
  input  wire mem_cmd_t                i_elf_req_cmd,
  input  wire logic [PADDR_W-1:0]      i_elf_req_addr,
  input  wire logic [REQ_TAG_W-1:0]    i_elf_req_tag,
  input  wire logic [DATA_W-1:0]       i_elf_req_data,
  input  wire logic [BYTE_EN_W-1:0]    i_elf_req_byte_en,
  output logic                         o_elf_req_ready,
  output logic                         o_elf_resp_valid,
  output logic [REQ_TAG_W-1:0]         o_elf_resp_tag,
  output logic [DATA_W-1:0]            o_elf_resp_data,
  input  wire logic                    i_elf_resp_ready,

  // instruction cache.
  input  wire logic                    i_ic_req_valid,
  input  wire mem_cmd_t                i_ic_req_cmd,
  input  wire logic [PADDR_W-1:0]      i_ic_req_addr,
  input  wire logic [REQ_TAG_W-1:0]    i_ic_req_tag,
  input  wire logic [DATA_W-1:0]       i_ic_req_data,
  input  wire logic [BYTE_EN_W-1:0]    i_ic_req_byte_en,
  output logic                         o_ic_req_ready,
  output logic                         o_ic_resp_valid,
  output logic [REQ_TAG_W-1:0]         o_ic_resp_tag,
  output logic [DATA_W-1:0]            o_ic_resp_data,
  input  wire logic                    i_ic_resp_ready,

  // l1 data cache.
  input  wire logic                    i_l1d_req_valid,
  input  wire mem_cmd_t                i_l1d_req_cmd,
  input  wire logic [PADDR_W-1:0]      i_l1d_req_addr,
  input  wire logic [REQ_TAG_W-1:0]    i_l1d_req_tag,
  input  wire logic [DATA_W-1:0]       i_l1d_req_data,
  input  wire logic [BYTE_EN_W-1:0]    i_l1d_req_byte_en,
  output logic                         o_l1d_req_ready,
  output logic                         o_l1d_resp_valid,
  output logic [REQ_TAG_W-1:0]         o_l1d_resp_tag,
  output logic [DATA_W-1:0]            o_l1d_resp_data,
  input  wire logic                    i_l1d_resp_ready,

  // page-table walker.
  input  wire logic                    i_ptw_req_valid,
  input  wire mem_cmd_t                i_ptw_req_cmd,
  input  wire logic [PADDR_W-1:0]      i_ptw_req_addr,
  input  wire logic [REQ_TAG_W-1:0]    i_ptw_req_tag,
  input  wire logic [DATA_W-1:0]       i_ptw_req_data,
  input  wire logic [BYTE_EN_W-1:0]    i_ptw_req_byte_en,
  output logic                         o_ptw_req_ready,
  output logic                         o_ptw_resp_valid,
  output logic [REQ_TAG_W-1:0]         o_ptw_resp_tag,
  output logic [DATA_W-1:0]            o_ptw_resp_data,
  input  wire logic                    i_ptw_resp_ready,

  // shared L2 port.
  output logic                         o_l2_req_valid,
  output mem_cmd_t                     o_l2_req_cmd,
  output logic [PADDR_W-1:0]           o_l2_req_addr,
  output logic [L2_CMD_TAG_W-1:0]      o_l2_req_tag,
  output logic [DATA_W-1:0]            o_l2_req_data,
  output logic [BYTE_EN_W-1:0]         o_l2_req_byte_en,
  input  wire logic                    i_l2_req_ready,
  input  wire logic                    i_l2_resp_valid,
  input  wire logic [L2_CMD_TAG_W-1:0] i_l2_resp_tag,
  input  wire logic [DATA_W-1:0]       i_l2_resp_data,
  output logic                         o_l2_resp_ready
);

  localparam int ARB_NUM = 4;

  l2_vr_if #(.T_PAYLOAD(l2_req_t))  req_if [ARB_NUM] ();
  l2_vr_if #(.T_PAYLOAD(l2_req_t))  req_sel_if ();
  l2_vr_if #(.T_PAYLOAD(l2_resp_t)) resp_l2_if ();
  l2_vr_if #(.T_PAYLOAD(l2_resp_t)) resp_if [ARB_NUM] ();

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // requests in, index = source id
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign req_if[0].valid   = i_elf_req_valid;
  assign req_if[0].payload = '{cmd: i_elf_req_cmd, addr: i_elf_req_addr,
                               tag: {{SRC_ID_W{1'b0}}, i_elf_req_tag},
                               data: i_elf_req_data, byte_en: i_elf_req_byte_en};
  assign o_elf_req_ready   = req_if[0].ready;

  assign req_if[1].valid   = i_ic_req_valid;
  assign req_if[1].payload = '{cmd: i_ic_req_cmd, addr: i_ic_req_addr,
                               tag: {{SRC_ID_W{1'b0}}, i_ic_req_tag},
                               data: i_ic_req_data, byte_en: i_ic_req_byte_en};
  assign o_ic_req_ready    = req_if[1].ready;

  assign req_if[2].valid   = i_l1d_req_valid;
  assign req_if[2].payload = '{cmd: i_l1d_req_cmd, addr: i_l1d_req_addr,
                               tag: {{SRC_ID_W{1'b0}}, i_l1d_req_tag},
                               data: i_l1d_req_data, byte_en: i_l1d_req_byte_en};
  assign o_l1d_req_ready   = req_if[2].ready;

  assign req_if[3].valid   = i_ptw_req_valid;
  assign req_if[3].payload = '{cmd: i_ptw_req_cmd, addr: i_ptw_req_addr,
                               tag: {{SRC_ID_W{1'b0}}, i_ptw_req_tag},
                               data: i_ptw_req_data, byte_en: i_ptw_req_byte_en};
  assign o_ptw_req_ready   = req_if[3].ready;

  l2_if_arbiter #(.ARB_NUM(ARB_NUM)) u_l2_if_arbiter (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .l2_slave_if  (req_if),
    .l2_master_if (req_sel_if)
  );

  assign o_l2_req_valid   = req_sel_if.valid;
  assign o_l2_req_cmd     = req_sel_if.payload.cmd;
  assign o_l2_req_addr    = req_sel_if.payload.addr;
  assign o_l2_req_tag     = req_sel_if.payload.tag;
  assign o_l2_req_data    = req_sel_if.payload.data;
  assign o_l2_req_byte_en = req_sel_if.payload.byte_en;
  assign req_sel_if.ready = i_l2_req_ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // responses out
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign resp_l2_if.valid   = i_l2_resp_valid;
  assign resp_l2_if.payload = '{tag: i_l2_resp_tag, data: i_l2_resp_data};
  assign o_l2_resp_ready    = resp_l2_if.ready;

  l2_resp_router #(.ARB_NUM(ARB_NUM)) u_l2_resp_router (
    .l2_resp_slave_if (resp_l2_if),
    .resp_master_if   (resp_if)
  );

  assign o_elf_resp_valid = resp_if[0].valid;
  assign o_elf_resp_tag   = resp_if[0].payload.tag[REQ_TAG_W-1:0];
  assign o_elf_resp_data  = resp_if[0].payload.data;
  assign resp_if[0].ready = i_elf_resp_ready;

  assign o_ic_resp_valid  = resp_if[1].valid;
  assign o_ic_resp_tag    = resp_if[1].payload.tag[REQ_TAG_W-1:0];
  assign o_ic_resp_data   = resp_if[1].payload.data;
  assign resp_if[1].ready = i_ic_resp_ready;

  assign o_l1d_resp_valid = resp_if[2].valid;
  assign o_l1d_resp_tag   = resp_if[2].payload.tag[REQ_TAG_W-1:0];
  assign o_l1d_resp_data  = resp_if[2].payload.data;
  assign resp_if[2].ready = i_l1d_resp_ready;

  assign o_ptw_resp_valid = resp_if[3].valid;
  assign o_ptw_resp_tag   = resp_if[3].payload.tag[REQ_TAG_W-1:0];
  assign o_ptw_resp_data  = resp_if[3].payload.data;
  assign resp_if[3].ready = i_ptw_resp_ready;

endmodule

`default_nettype wire

// ==== src/l2_resp_router.sv ====
`timescale 1ns/10ps
`default_nettype none

module l2_resp_router
  import l2c_pkg::*;
#(
  parameter int ARB_NUM = 4
) (
  l2_vr_if.slave  l2_resp_slave_if,
  l2_vr_if.master resp_master_if [ARB_NUM]
);

  logic [SRC_ID_W-1:0] dst_idx;
  l2_resp_t            resp_in;
  l2_resp_t            resp_local;
  logic [ARB_NUM-1:0]  ready_vec;
  logic                dst_mapped;

  assign resp_in    = l2_resp_slave_if.payload;
  assign dst_idx    = resp_in.tag[L2_CMD_TAG_W-1 -: SRC_ID_W];
  assign dst_mapped = (int'(dst_idx) < ARB_NUM);

  // requester only sees its own tag.
  always_comb begin
    resp_local = resp_in;
    resp_local.tag[L2_CMD_TAG_W-1 -: SRC_ID_W] = '0;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per-requester steering
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar i = 0; i < ARB_NUM; i++) begin : g_master
    assign resp_master_if[i].valid   = l2_resp_slave_if.valid &
                                       (dst_idx == SRC_ID_W'(i));
    assign resp_master_if[i].payload = resp_local;
    assign ready_vec[i]              = resp_master_if[i].ready;
  end

  // unmapped source ids are accepted and dropped so L2 never hangs.
  always_comb begin
    l2_resp_slave_if.ready = 1'b1;
    if (dst_mapped) begin
      l2_resp_slave_if.ready = ready_vec[dst_idx];
    end
  end

endmodule

`default_nettype wire

// ==== src/l2_if_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module l2_if_arbiter
  import l2c_pkg::*;
#(
  parameter int ARB_NUM = 4
) (
  input  wire logic i_clk,
  input  wire logic i_rst,
  l2_vr_if.slave    l2_slave_if [ARB_NUM],
  l2_vr_if.master   l2_master_if
);

  logic [ARB_NUM-1:0]  valid_vec;
  l2_req_t             payload_arr [ARB_NUM];

  logic [SRC_ID_W-1:0] rr_ptr_q;
  logic                lock_q;
  logic [SRC_ID_W-1:0] lock_idx_q;

  logic                search_found;
  logic [SRC_ID_W-1:0] search_idx;
  logic [SRC_ID_W-1:0] grant_idx;
  logic                grant_vld;
  logic                xfer;
  l2_req_t             fwd_req;

  if (ARB_NUM < 2 || ARB_NUM > (2 ** SRC_ID_W)) begin : g_bad_arb_num
    $error("ARB_NUM out of range for SRC_ID_W");
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // requester side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar i = 0; i < ARB_NUM; i++) begin : g_slave
    assign valid_vec[i]         = l2_slave_if[i].valid;
    assign payload_arr[i]       = l2_slave_if[i].payload;
    // only the granted requester sees ready.
    assign l2_slave_if[i].ready = l2_master_if.ready & grant_vld &
                                  (grant_idx == SRC_ID_W'(i));
  end

  // first valid requester at or after the pointer.
  always_comb begin
    int cand;
    search_found = 1'b0;
    search_idx   = '0;
    for (int k = 0; k < ARB_NUM; k++) begin
      cand = (int'(rr_ptr_q) + k) % ARB_NUM;
      if (!search_found && valid_vec[cand]) begin
        search_found = 1'b1;
        search_idx   = SRC_ID_W'(cand);
      end
    end
  end

  assign grant_idx = lock_q ? lock_idx_q : search_idx;
  assign grant_vld = lock_q ? valid_vec[lock_idx_q] : search_found;
  assign xfer      = grant_vld & l2_master_if.ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pointer and lock
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rr_ptr_q   <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (xfer) begin
      lock_q   <= 1'b0;
      rr_ptr_q <= (grant_idx == SRC_ID_W'(ARB_NUM - 1)) ? '0 : grant_idx + 1'b1;
    end else if (grant_vld) begin
      // stalled by L2, hold this grant.
      lock_q     <= 1'b1;
      lock_idx_q <= grant_idx;
    end
  end

  // tag prefix carries the source index.
  always_comb begin
    fwd_req = payload_arr[grant_idx];
    fwd_req.tag[L2_CMD_TAG_W-1 -: SRC_ID_W] = grant_idx;
  end

  assign l2_master_if.valid   = grant_vld;
  assign l2_master_if.payload = fwd_req;

endmodule

`default_nettype wire

// ==== src/l2_vr_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface l2_vr_if #(
  parameter type T_PAYLOAD = logic
);

  logic     valid;
  logic     ready;
  T_PAYLOAD payload;

  // source side.
  modport master (
    output valid,
    output payload,
    input  ready
  );

  // sink side.
  modport slave (
    input  valid,
    input  payload,
    output ready
  );

  modport monitor (
    input valid,
    input ready,
    input payload
  );

endinterface

`default_nettype wire

// ==== src/l2c_pkg.sv ====
`default_nettype none

package l2c_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int PADDR_W      = 32;
  localparam int DATA_W       = 64;
  localparam int BYTE_EN_W    = DATA_W / 8;
  localparam int REQ_TAG_W    = 4;
  localparam int SRC_ID_W     = 2;
  // source index sits above the requester tag.
  localparam int L2_CMD_TAG_W = SRC_ID_W + REQ_TAG_W;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // payload types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [0:0] {
    M_XRD = 1'b0,
    M_XWR = 1'b1
  } mem_cmd_t;

  // upper SRC_ID_W tag bits are zero on the requester side.
  typedef struct packed {
    mem_cmd_t                 cmd;
    logic [PADDR_W-1:0]       addr;
    logic [L2_CMD_TAG_W-1:0]  tag;
    logic [DATA_W-1:0]        data;
    logic [BYTE_EN_W-1:0]     byte_en;
  } l2_req_t;

  typedef struct packed {
    logic [L2_CMD_TAG_W-1:0]  tag;
    logic [DATA_W-1:0]        data;
  } l2_resp_t;

endpackage

`default_nettype wire
